//--- logic/md_pkg.sv
package md_pkg;

   typedef logic [31:0] word_t;
   typedef logic [63:0] dword_t;   // product, or remainder and quotient
   typedef logic [34:0] pp_t;      // booth partial product with sign prefix

   typedef enum logic {
      MD_OP_MUL,
      MD_OP_DIV
   } md_op_e;

   typedef enum logic {
      MD_OUT_LO,
      MD_OUT_HI
   } md_out_e;

   typedef enum logic [1:0] {
      IDLE,
      MUL_BUSY,
      DIV_BUSY
   } md_state_e;

   localparam int MUL_CYCLES = 9;    // two booth digits per cycle, 18 digits
   localparam int DIV_CYCLES = 16;   // two quotient bits per cycle

endpackage

//--- logic/md_booth_recoder.sv
module md_booth_recoder (
   input  logic          [2:0] group,
   input  md_pkg::word_t       multiplicand,
   input  logic                multiplicand_signed,
   input  logic                first_digit,
   output md_pkg::pp_t         partial,
   output logic                negate
);

   logic        ext;
   logic        sign;
   logic [32:0] field;

   assign ext    = multiplicand[31] & multiplicand_signed;
   assign negate = (group[2:1] == 2'b10) | (group == 3'b110);   // -1 and -2 digits
   assign sign   = ((group == 3'b000) || (group == 3'b111)) ? 1'b0 : ext ^ group[2];

   // negative digits are one's complement, negate supplies the +1
   always_comb begin
      case (group)
         3'b001, 3'b010: field = {ext, multiplicand};
         3'b011:         field = {multiplicand, 1'b0};
         3'b100:         field = ~{multiplicand, 1'b0};
         3'b101, 3'b110: field = ~{ext, multiplicand};
         default:        field = '0;
      endcase
   end

   // first digit prefix is {~s,s,s}, its top bit lands above pp_t in the multiplier
   assign partial = first_digit ? {sign, sign, field} : {1'b1, ~sign, field};

endmodule

//--- logic/md_multiplier.sv
module md_multiplier (
   input  logic           clk,
   input  logic           reset,
   input  logic           start,
   input  md_pkg::word_t  multiplicand,
   input  md_pkg::word_t  multiplier,
   input  logic           multiplicand_signed,
   input  logic           multiplier_signed,
   output md_pkg::dword_t product,
   output logic           done
);

   logic [34:0]    mr_q;   // {ext, ext, multiplier, b(-1)}
   md_pkg::dword_t sum_q;
   md_pkg::dword_t carry_q;
   logic [3:0]     cnt_q;
   logic           busy_q;
   logic           fin_q;
   logic           ext;
   logic           first;
   md_pkg::pp_t    pp_lo;
   md_pkg::pp_t    pp_hi;
   logic           neg_lo;
   logic           neg_hi;
   logic [5:0]     shamt;
   md_pkg::dword_t add_lo;
   md_pkg::dword_t add_hi;
   md_pkg::dword_t add_neg;
   md_pkg::dword_t sum_1;
   md_pkg::dword_t carry_1;
   md_pkg::dword_t sum_2;
   md_pkg::dword_t carry_2;
   md_pkg::dword_t sum_3;
   md_pkg::dword_t carry_3;

   function automatic void csa(input md_pkg::dword_t a, input md_pkg::dword_t b,
                               input md_pkg::dword_t c, output md_pkg::dword_t s,
                               output md_pkg::dword_t cy);
      s  = a ^ b ^ c;
      cy = ((a & b) | (b & c) | (a & c)) << 1;
   endfunction

   assign ext   = multiplier_signed & multiplier[31];
   assign first = (cnt_q == 4'd0);
   assign shamt = {cnt_q, 2'b00};

   md_booth_recoder booth_lo_i (
      .group               (mr_q[2:0]),
      .multiplicand        (multiplicand),
      .multiplicand_signed (multiplicand_signed),
      .first_digit         (first),
      .partial             (pp_lo),
      .negate              (neg_lo)
   );

   md_booth_recoder booth_hi_i (
      .group               (mr_q[4:2]),
      .multiplicand        (multiplicand),
      .multiplicand_signed (multiplicand_signed),
      .first_digit         (1'b0),
      .partial             (pp_hi),
      .negate              (neg_hi)
   );

   assign add_lo = md_pkg::dword_t'(pp_lo) << shamt;
   assign add_hi = md_pkg::dword_t'(pp_hi) << (shamt + 6'd2);

   always_comb begin
      add_neg = (md_pkg::dword_t'(neg_lo) << shamt) |
                (md_pkg::dword_t'(neg_hi) << (shamt + 6'd2));
      if (first)
         add_neg[35] = ~pp_lo[34];   // completes the first digit's prefix
      csa(sum_q, carry_q, add_lo, sum_1, carry_1);
      csa(sum_1, carry_1, add_hi, sum_2, carry_2);
      csa(sum_2, carry_2, add_neg, sum_3, carry_3);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         busy_q <= 1'b0;
         fin_q  <= 1'b0;
         cnt_q  <= '0;
         done   <= 1'b0;
      end else begin
         done <= fin_q;
         if (start) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
         end else if (busy_q) begin
            cnt_q <= cnt_q + 4'd1;
            if (cnt_q == 4'(md_pkg::MUL_CYCLES - 1)) begin
               busy_q <= 1'b0;
               fin_q  <= 1'b1;
            end
         end else begin
            fin_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         mr_q    <= {{2{ext}}, multiplier, 1'b0};
         sum_q   <= '0;
         carry_q <= '0;
      end else if (busy_q) begin
         mr_q    <= {{4{mr_q[34]}}, mr_q[34:4]};
         sum_q   <= sum_3;
         carry_q <= carry_3;
      end
      if (fin_q)
         product <= sum_q + carry_q;   // prefix constants wrap out above bit 63
   end

endmodule

//--- logic/md_divider.sv
module md_divider (
   input  logic          clk,
   input  logic          reset,
   input  logic          start,
   input  md_pkg::word_t dividend,
   input  md_pkg::word_t divisor,
   input  logic          is_signed,
   output md_pkg::word_t quotient,
   output md_pkg::word_t remainder,
   output logic          done
);

   md_pkg::word_t dividend_mag;
   md_pkg::word_t divisor_mag;
   logic          divisor_zero;
   md_pkg::word_t div_q;
   md_pkg::word_t rem_q;
   md_pkg::word_t quo_q;   // dividend bits leave the top, digits enter the bottom
   logic          q_neg;
   logic          r_neg;
   logic [3:0]    cnt_q;
   logic          busy_q;
   logic          fin_q;
   logic [33:0]   shifted;
   logic [34:0]   diff_1;
   logic [34:0]   diff_2;
   logic [34:0]   diff_3;
   logic [1:0]    digit;
   md_pkg::word_t rem_next;

   assign dividend_mag = (is_signed && dividend[31]) ? -dividend : dividend;
   assign divisor_mag  = (is_signed && divisor[31]) ? -divisor : divisor;
   assign divisor_zero = (divisor == '0);

   assign shifted = {rem_q, quo_q[31:30]};
   assign diff_1  = {1'b0, shifted} - {3'b000, div_q};
   assign diff_2  = {1'b0, shifted} - {2'b00, div_q, 1'b0};
   assign diff_3  = {1'b0, shifted} - ({3'b000, div_q} + {2'b00, div_q, 1'b0});

   // largest multiple that leaves a non-negative remainder
   always_comb begin
      if (!diff_3[34]) begin
         digit    = 2'd3;
         rem_next = diff_3[31:0];
      end else if (!diff_2[34]) begin
         digit    = 2'd2;
         rem_next = diff_2[31:0];
      end else if (!diff_1[34]) begin
         digit    = 2'd1;
         rem_next = diff_1[31:0];
      end else begin
         digit    = 2'd0;
         rem_next = shifted[31:0];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         busy_q <= 1'b0;
         fin_q  <= 1'b0;
         cnt_q  <= '0;
         done   <= 1'b0;
      end else begin
         done <= fin_q;
         if (start) begin
            busy_q <= !divisor_zero;
            fin_q  <= divisor_zero;   // skip the iterations
            cnt_q  <= '0;
         end else if (busy_q) begin
            cnt_q <= cnt_q + 4'd1;
            if (cnt_q == 4'(md_pkg::DIV_CYCLES - 1)) begin
               busy_q <= 1'b0;
               fin_q  <= 1'b1;
            end
         end else begin
            fin_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         div_q <= divisor_mag;
         if (divisor_zero) begin
            rem_q <= dividend;
            quo_q <= '1;
            q_neg <= 1'b0;
            r_neg <= 1'b0;
         end else begin
            rem_q <= '0;
            quo_q <= dividend_mag;
            q_neg <= is_signed && (dividend[31] ^ divisor[31]);
            r_neg <= is_signed && dividend[31];   // remainder follows the dividend
         end
      end else if (busy_q) begin
         rem_q <= rem_next;
         quo_q <= {quo_q[29:0], digit};
      end
      if (fin_q) begin
         quotient  <= q_neg ? -quo_q : quo_q;
         remainder <= r_neg ? -rem_q : rem_q;
      end
   end

endmodule

//--- logic/md_unit.sv
module md_unit (
   input  logic            clk,
   input  logic            reset,
   input  logic            req_valid,
   output logic            req_ready,
   input  md_pkg::md_op_e  req_op,
   input  md_pkg::md_out_e req_out_sel,
   input  logic            req_in_1_signed,
   input  logic            req_in_2_signed,
   input  md_pkg::word_t   req_in_1,
   input  md_pkg::word_t   req_in_2,
   output logic            resp_valid,
   output md_pkg::word_t   resp_result
);

   md_pkg::md_state_e state;
   md_pkg::md_op_e    op_q;
   md_pkg::md_out_e   out_sel_q;
   md_pkg::word_t     in_1_q;
   md_pkg::word_t     in_2_q;
   logic              in_1_signed_q;
   logic              in_2_signed_q;
   logic              accept;
   logic              start_mul;
   logic              start_div;
   logic              mul_done;
   logic              div_done;
   md_pkg::dword_t    product;
   md_pkg::word_t     quotient;
   md_pkg::word_t     remainder;
   md_pkg::word_t     mul_word;
   md_pkg::word_t     div_word;

   assign req_ready = (state == md_pkg::IDLE) || resp_valid;   // ready again in strobe cycle
   assign accept    = req_valid && req_ready;

   always_comb begin
      case (state)
         md_pkg::MUL_BUSY: resp_valid = mul_done;
         md_pkg::DIV_BUSY: resp_valid = div_done;
         default:          resp_valid = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= md_pkg::IDLE;
         start_mul <= 1'b0;
         start_div <= 1'b0;
      end else begin
         start_mul <= accept && (req_op == md_pkg::MD_OP_MUL);
         start_div <= accept && (req_op == md_pkg::MD_OP_DIV);
         if (accept)
            state <= (req_op == md_pkg::MD_OP_MUL) ? md_pkg::MUL_BUSY : md_pkg::DIV_BUSY;
         else if (resp_valid)
            state <= md_pkg::IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         op_q          <= req_op;
         out_sel_q     <= req_out_sel;
         in_1_q        <= req_in_1;
         in_2_q        <= req_in_2;
         in_1_signed_q <= req_in_1_signed;
         in_2_signed_q <= req_in_2_signed;
      end
   end

   // rs1 is the recoded operand, rs2 the multiplicand
   md_multiplier mul_i (
      .clk                 (clk),
      .reset               (reset),
      .start               (start_mul),
      .multiplicand        (in_2_q),
      .multiplier          (in_1_q),
      .multiplicand_signed (in_2_signed_q),
      .multiplier_signed   (in_1_signed_q),
      .product             (product),
      .done                (mul_done)
   );

   md_divider div_i (
      .clk       (clk),
      .reset     (reset),
      .start     (start_div),
      .dividend  (in_1_q),
      .divisor   (in_2_q),
      .is_signed (in_1_signed_q),   // one flag covers both operands
      .quotient  (quotient),
      .remainder (remainder),
      .done      (div_done)
   );

   assign mul_word    = (out_sel_q == md_pkg::MD_OUT_HI) ? product[63:32] : product[31:0];
   assign div_word    = (out_sel_q == md_pkg::MD_OUT_HI) ? remainder : quotient;
   assign resp_result = (op_q == md_pkg::MD_OP_MUL) ? mul_word : div_word;

endmodule

//--- dv/md_clock_gen.sv
module md_clock_gen (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;   // period 10
   end

   initial begin
      reset = 1'b1;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

//--- dv/md_checker.sv
module md_checker (
   input  logic            clk,
   input  logic            reset,
   input  logic            req_valid,
   input  logic            req_ready,
   input  md_pkg::md_op_e  req_op,
   input  md_pkg::md_out_e req_out_sel,
   input  logic            req_in_1_signed,
   input  logic            req_in_2_signed,
   input  md_pkg::word_t   req_in_1,
   input  md_pkg::word_t   req_in_2,
   input  logic            resp_valid,
   input  md_pkg::word_t   resp_result,
   input  logic [127:0]    row_name,
   input  md_pkg::word_t   row_exp,
   input  logic            row_fixed,
   output int              value_errors,
   output int              latency_errors,
   output int              protocol_errors,
   output int              accept_count,
   output int              resp_count
);

   int            cycle;
   int            acc_cycle;
   int            lat;
   int            exp_lat;
   logic          busy;
   logic          prev_resp;
   logic [127:0]  acc_name;
   md_pkg::word_t acc_exp;

   // exact result under the RISC-V M rules
   function automatic md_pkg::word_t model(input md_pkg::md_op_e op, input md_pkg::md_out_e sel,
                                           input logic s1, input logic s2,
                                           input md_pkg::word_t a, input md_pkg::word_t b);
      longint x;
      longint y;
      longint p;
      md_pkg::word_t q;
      md_pkg::word_t r;
      x = s1 ? longint'($signed(a)) : longint'({32'h0, a});
      if (op == md_pkg::MD_OP_MUL) begin
         y = s2 ? longint'($signed(b)) : longint'({32'h0, b});
         p = x * y;   // low 64 bits are exact
         return (sel == md_pkg::MD_OUT_HI) ? p[63:32] : p[31:0];
      end
      y = s1 ? longint'($signed(b)) : longint'({32'h0, b});   // divide uses rs1's flag
      if (b == 32'h0) begin
         q = 32'hffff_ffff;
         r = a;
      end else if (s1 && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
         q = a;
         r = 32'h0;
      end else begin
         p = x / y;   // truncates toward zero
         q = p[31:0];
         p = x % y;   // sign of dividend
         r = p[31:0];
      end
      return (sel == md_pkg::MD_OUT_HI) ? r : q;
   endfunction

   initial begin
      cycle = 0;
      busy = 1'b0;
      prev_resp = 1'b0;
      value_errors = 0;
      latency_errors = 0;
      protocol_errors = 0;
      accept_count = 0;
      resp_count = 0;
   end

   always @(posedge clk) begin
      cycle = cycle + 1;
      if (!reset) begin
         if (busy && !resp_valid && req_ready) begin
            $display("req_ready high while an operation is busy at cycle %0d", cycle);
            protocol_errors = protocol_errors + 1;
         end
         if (!busy && !req_ready) begin
            $display("req_ready low while idle at cycle %0d", cycle);
            protocol_errors = protocol_errors + 1;
         end
         if (resp_valid && prev_resp) begin
            $display("resp_valid stayed high longer than one cycle at cycle %0d", cycle);
            protocol_errors = protocol_errors + 1;
         end
         if (resp_valid)
            resp_count = resp_count + 1;   // every strobe, pending or not
         if (resp_valid && !busy) begin
            $display("response with no request pending at cycle %0d", cycle);
            protocol_errors = protocol_errors + 1;
         end else if (resp_valid) begin
            busy = 1'b0;
            lat = cycle - acc_cycle - 1;   // edge at which resp_valid rose
            if (lat != exp_lat) begin
               $display("latency of %s was %0d cycles, expected %0d", acc_name, lat, exp_lat);
               latency_errors = latency_errors + 1;
            end
            if (resp_result !== acc_exp) begin
               $display("error %s: expected %h, actual %h", acc_name, acc_exp, resp_result);
               value_errors = value_errors + 1;
            end
         end
         if (req_valid && req_ready) begin   // after the response, same edge is allowed
            accept_count = accept_count + 1;
            busy = 1'b1;
            acc_cycle = cycle;
            acc_name = row_name;
            acc_exp = row_fixed ? row_exp : model(req_op, req_out_sel, req_in_1_signed,
                                                  req_in_2_signed, req_in_1, req_in_2);
            if (req_op == md_pkg::MD_OP_MUL)
               exp_lat = md_pkg::MUL_CYCLES + 2;
            else if (req_in_2 == 32'h0)
               exp_lat = 2;
            else
               exp_lat = md_pkg::DIV_CYCLES + 2;
         end
         prev_resp = resp_valid;
      end
   end

endmodule

//--- dv/md_unit_tb.sv
module md_unit_tb;

   localparam int NUM_DIRECTED = 15;
   localparam int NUM_RANDOM = 25;
   localparam int NUM_ROWS = NUM_DIRECTED + NUM_RANDOM;
   localparam int TIMEOUT = NUM_ROWS * 20 + 50;

   logic            clk;
   logic            reset;
   logic            req_valid;
   logic            req_ready;
   md_pkg::md_op_e  req_op;
   md_pkg::md_out_e req_out_sel;
   logic            req_in_1_signed;
   logic            req_in_2_signed;
   md_pkg::word_t   req_in_1;
   md_pkg::word_t   req_in_2;
   logic            resp_valid;
   md_pkg::word_t   resp_result;
   logic [127:0]    row_name;
   md_pkg::word_t   row_exp;
   logic            row_fixed;
   int              value_errors;
   int              latency_errors;
   int              protocol_errors;
   int              accept_count;
   int              resp_count;
   int              count_errors;
   int              cycles = 0;
   int              n_rows;
   logic [31:0]     rnd;

   logic [127:0]    name_tab  [NUM_ROWS];
   md_pkg::md_op_e  op_tab    [NUM_ROWS];
   md_pkg::md_out_e out_tab   [NUM_ROWS];
   logic            s1_tab    [NUM_ROWS];
   logic            s2_tab    [NUM_ROWS];
   md_pkg::word_t   a_tab     [NUM_ROWS];
   md_pkg::word_t   b_tab     [NUM_ROWS];
   md_pkg::word_t   exp_tab   [NUM_ROWS];
   logic            fixed_tab [NUM_ROWS];

   md_clock_gen clk_gen_i (
      .clk   (clk),
      .reset (reset)
   );

   md_unit dut_i (
      .clk             (clk),
      .reset           (reset),
      .req_valid       (req_valid),
      .req_ready       (req_ready),
      .req_op          (req_op),
      .req_out_sel     (req_out_sel),
      .req_in_1_signed (req_in_1_signed),
      .req_in_2_signed (req_in_2_signed),
      .req_in_1        (req_in_1),
      .req_in_2        (req_in_2),
      .resp_valid      (resp_valid),
      .resp_result     (resp_result)
   );

   md_checker checker_i (
      .clk             (clk),
      .reset           (reset),
      .req_valid       (req_valid),
      .req_ready       (req_ready),
      .req_op          (req_op),
      .req_out_sel     (req_out_sel),
      .req_in_1_signed (req_in_1_signed),
      .req_in_2_signed (req_in_2_signed),
      .req_in_1        (req_in_1),
      .req_in_2        (req_in_2),
      .resp_valid      (resp_valid),
      .resp_result     (resp_result),
      .row_name        (row_name),
      .row_exp         (row_exp),
      .row_fixed       (row_fixed),
      .value_errors    (value_errors),
      .latency_errors  (latency_errors),
      .protocol_errors (protocol_errors),
      .accept_count    (accept_count),
      .resp_count      (resp_count)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic add_row(input logic [127:0] name, input md_pkg::md_op_e op,
                          input md_pkg::md_out_e sel, input logic s1, input logic s2,
                          input logic [31:0] a, input logic [31:0] b, input logic [31:0] exp);
      name_tab[n_rows] = name;
      op_tab[n_rows] = op;
      out_tab[n_rows] = sel;
      s1_tab[n_rows] = s1;
      s2_tab[n_rows] = s2;
      a_tab[n_rows] = a;
      b_tab[n_rows] = b;
      exp_tab[n_rows] = exp;
      fixed_tab[n_rows] = 1'b1;
      n_rows = n_rows + 1;
   endtask

   task automatic fill_random_rows();
      logic [127:0] name;
      int k;
      for (int j = 0; j < NUM_RANDOM; j++) begin
         $sformat(name, "rand_%0d", j);
         k = (j / 4) % 3;   // unsigned, signed, signed by unsigned
         name_tab[n_rows] = name;
         op_tab[n_rows] = (j % 2) ? md_pkg::MD_OP_DIV : md_pkg::MD_OP_MUL;
         out_tab[n_rows] = ((j / 2) % 2) ? md_pkg::MD_OUT_HI : md_pkg::MD_OUT_LO;
         s1_tab[n_rows] = (k != 0);
         s2_tab[n_rows] = (j % 2) ? (k != 0) : (k == 1);
         rnd = xorshift(rnd);
         a_tab[n_rows] = rnd;
         rnd = xorshift(rnd);
         b_tab[n_rows] = (j % 2) ? (rnd >> rnd[4:0]) : rnd;   // varied divisor sizes
         exp_tab[n_rows] = 32'h0;
         fixed_tab[n_rows] = 1'b0;
         n_rows = n_rows + 1;
      end
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("timeout after %0d cycles with %0d of %0d responses", cycles, resp_count,
                  NUM_ROWS);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   initial begin
      req_valid = 1'b0;
      req_op = md_pkg::MD_OP_MUL;
      req_out_sel = md_pkg::MD_OUT_LO;
      req_in_1_signed = 1'b0;
      req_in_2_signed = 1'b0;
      req_in_1 = '0;
      req_in_2 = '0;
      row_name = '0;
      row_exp = '0;
      row_fixed = 1'b0;
      count_errors = 0;
      n_rows = 0;
      rnd = 32'd8896;

      add_row("mulu_ones_lo", md_pkg::MD_OP_MUL, md_pkg::MD_OUT_LO, 0, 0,
              32'hffff_ffff, 32'hffff_ffff, 32'h0000_0001);
      add_row("mulu_ones_hi", md_pkg::MD_OP_MUL, md_pkg::MD_OUT_HI, 0, 0,
              32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
      add_row("mulh_neg1", md_pkg::MD_OP_MUL, md_pkg::MD_OUT_HI, 1, 1,
              32'hffff_ffff, 32'hffff_ffff, 32'h0000_0000);
      add_row("mulh_minneg", md_pkg::MD_OP_MUL, md_pkg::MD_OUT_HI, 1, 1,
              32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
      add_row("mulhsu_ones", md_pkg::MD_OP_MUL, md_pkg::MD_OUT_HI, 1, 0,
              32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff);
      add_row("mul_zero", md_pkg::MD_OP_MUL, md_pkg::MD_OUT_LO, 1, 1,
              32'h0000_0000, 32'h1234_5678, 32'h0000_0000);
      add_row("mulh_one", md_pkg::MD_OP_MUL, md_pkg::MD_OUT_HI, 1, 1,
              32'h0000_0001, 32'h8000_0000, 32'hffff_ffff);
      add_row("divu_small", md_pkg::MD_OP_DIV, md_pkg::MD_OUT_LO, 0, 0,
              32'd100, 32'd7, 32'd14);
      add_row("remu_small", md_pkg::MD_OP_DIV, md_pkg::MD_OUT_HI, 0, 0,
              32'd100, 32'd7, 32'd2);
      add_row("div_neg", md_pkg::MD_OP_DIV, md_pkg::MD_OUT_LO, 1, 1,
              32'hffff_ff9c, 32'd7, 32'hffff_fff2);   // -100 / 7
      add_row("rem_neg", md_pkg::MD_OP_DIV, md_pkg::MD_OUT_HI, 1, 1,
              32'hffff_ff9c, 32'd7, 32'hffff_fffe);
      add_row("div_zero", md_pkg::MD_OP_DIV, md_pkg::MD_OUT_LO, 0, 0,
              32'h1234_5678, 32'h0, 32'hffff_ffff);
      add_row("rem_zero_neg", md_pkg::MD_OP_DIV, md_pkg::MD_OUT_HI, 1, 1,
              32'hffff_ff9c, 32'h0, 32'hffff_ff9c);
      add_row("div_ovf", md_pkg::MD_OP_DIV, md_pkg::MD_OUT_LO, 1, 1,
              32'h8000_0000, 32'hffff_ffff, 32'h8000_0000);
      add_row("rem_ovf", md_pkg::MD_OP_DIV, md_pkg::MD_OUT_HI, 1, 1,
              32'h8000_0000, 32'hffff_ffff, 32'h0000_0000);
      fill_random_rows();

      @(posedge clk);
      while (reset)
         @(posedge clk);
      for (int i = 0; i < NUM_ROWS; i++) begin
         req_valid <= 1'b1;
         req_op <= op_tab[i];
         req_out_sel <= out_tab[i];
         req_in_1_signed <= s1_tab[i];
         req_in_2_signed <= s2_tab[i];
         req_in_1 <= a_tab[i];
         req_in_2 <= b_tab[i];
         row_name <= name_tab[i];
         row_exp <= exp_tab[i];
         row_fixed <= fixed_tab[i];
         @(posedge clk);
         while (!req_ready)   // valid stays high while busy
            @(posedge clk);
      end
      req_valid <= 1'b0;

      while (resp_count < NUM_ROWS)
         @(posedge clk);
      repeat (4) @(posedge clk);
      if (accept_count != NUM_ROWS || resp_count != NUM_ROWS) begin
         $display("%0d requests accepted and %0d answered for %0d rows", accept_count,
                  resp_count, NUM_ROWS);
         count_errors = count_errors + 1;
      end
      $display("value errors %0d, latency errors %0d, protocol errors %0d, count errors %0d",
               value_errors, latency_errors, protocol_errors, count_errors);
      if (value_errors + latency_errors + protocol_errors + count_errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule

//--- all.f
logic/md_pkg.sv
logic/md_booth_recoder.sv
logic/md_multiplier.sv
logic/md_divider.sv
logic/md_unit.sv
dv/md_clock_gen.sv
dv/md_checker.sv
dv/md_unit_tb.sv

//--- Bender.yml
package:
  name: md_unit

sources:
  - files:
      - logic/md_pkg.sv
      - logic/md_booth_recoder.sv
      - logic/md_multiplier.sv
      - logic/md_divider.sv
      - logic/md_unit.sv
  - target: test
    files:
      - dv/md_clock_gen.sv
      - dv/md_checker.sv
      - dv/md_unit_tb.sv
